// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for the pass line"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module mem_subsystem_tb -f files.f -Mdir obj_dir -o Vsim
	./obj_dir/Vsim 2>&1 | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: dv/mem_subsystem_tb.sv
// Random stimulus from a fixed seed; clear is raised only in the first cycle an item is held.
module mem_subsystem_tb import mem_stage_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ITEMS  = 2000;
    localparam int WAIT_LIMIT = 50;

    // One expected writeback record.
    typedef struct packed {
        pc_t    pc;
        insn_t  insn;
        logic   use_rd;
        logic   trap;
        cause_t cause;
        word_t  rd_val;
        logic   aq;
        logic   rl;
    } expect_t;

    logic   clk;
    logic   rst;
    logic   clear;
    logic   in_valid;
    logic   in_ready;
    pc_t    in_pc;
    insn_t  in_insn;
    logic   in_use_rd;
    word_t  in_rs1_val;
    word_t  in_rs2_val;
    logic   in_trap;
    cause_t in_cause;
    logic   out_valid;
    pc_t    out_pc;
    insn_t  out_insn;
    logic   out_use_rd;
    word_t  out_rd_val;
    logic   out_trap;
    cause_t out_cause;
    logic   fence_aq;
    logic   fence_rl;

    // Next record to drive.
    pc_t    rec_pc;
    insn_t  rec_insn;
    logic   rec_use_rd;
    word_t  rec_rs1;
    word_t  rec_rs2;
    logic   rec_trap;
    cause_t rec_cause;

    // Reference model state.
    word_t   ram_model [RAM_WORDS];
    word_t   mscratch_model;
    word_t   mtvec_model;
    expect_t exp_q [$];
    expect_t head;
    int      gap;

    mem_subsystem_top mem_subsystem_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic end_with_failure();
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_equal(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERROR: time %0t signal %s got %h expected %h", $time, name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic random_record();
        int         kind;
        logic [4:0] op;
        logic [2:0] f3;
        logic [1:0] off;
        kind       = int'($urandom_range(99, 0));
        rec_insn   = insn_t'($urandom);
        rec_pc     = pc_t'($urandom);
        rec_use_rd = 1'($urandom_range(1, 0));
        rec_rs1    = word_t'($urandom);
        rec_rs2    = word_t'($urandom);
        rec_trap   = $urandom_range(19, 0) == 0;
        rec_cause  = cause_t'($urandom_range(15, 0));
        f3         = rec_insn[14:12];
        if (kind < 65) begin
            op = kind < 40 ? OP_LOAD : OP_STORE;
            if (op == OP_LOAD) begin
                case ($urandom_range(4, 0))
                    0:       f3 = 3'b000;
                    1:       f3 = 3'b001;
                    2:       f3 = 3'b010;
                    3:       f3 = 3'b100;
                    default: f3 = 3'b101;
                endcase
            end else begin
                f3 = 3'($urandom_range(2, 0));
            end
            // Mostly aligned offsets.
            off = 2'($urandom_range(3, 0));
            if ($urandom_range(9, 0) != 0) begin
                if (f3[1:0] == SIZE_WORD) begin
                    off = 2'b00;
                end else if (f3[1:0] == SIZE_HALF) begin
                    off[0] = 1'b0;
                end
            end
            // 16-word window; bits 11:10 land outside the RAM and wrap.
            rec_rs1 = (word_t'($urandom_range(3, 0)) << 10)
                    | (word_t'($urandom_range(15, 0)) << 2) | word_t'(off);
        end else if (kind < 85) begin
            op = OP_SYSTEM;
            f3 = {1'($urandom_range(1, 0)), 2'($urandom_range(3, 1))};
            case ($urandom_range(7, 0))
                0, 1, 2: rec_insn[31:20] = CSR_MSCRATCH;
                3, 4:    rec_insn[31:20] = CSR_MTVEC;
                5, 6:    rec_insn[31:20] = CSR_MVENDORID;
                default: rec_insn[31:20] = csr_addr_t'(12'h7C0 + $urandom_range(15, 0));
            endcase
            if ($urandom_range(3, 0) == 0) begin
                rec_insn[19:15] = 5'd0;
            end
        end else if (kind < 90) begin
            op = OP_MISC_MEM;
            f3 = 3'b000;
            if ($urandom_range(3, 0) == 0) begin
                rec_insn[27:24] = 4'd0;
            end
            if ($urandom_range(3, 0) == 0) begin
                rec_insn[23:20] = 4'd0;
            end
        end else begin
            // Register or immediate ALU op.
            op = $urandom_range(1, 0) == 0 ? 5'b01100 : 5'b00100;
        end
        rec_insn[6:0]   = {op, 2'b11};
        rec_insn[14:12] = f3;
    endtask

    // Apply one accepted record to the model, queue its result unless cleared.
    task automatic predict_item(input logic cleared);
        expect_t    e;
        logic [4:0] op;
        logic [2:0] f3;
        logic [1:0] off;
        int         idx;
        word_t      word;
        word_t      old;
        word_t      src;
        logic       exists;
        logic       write_csr;
        logic       bad_align;
        op        = rec_insn[6:2];
        f3        = rec_insn[14:12];
        off       = rec_rs1[1:0];
        idx       = int'(rec_rs1[RAM_ADDR_BITS+1:2]);
        e         = '0;
        e.pc      = rec_pc;
        e.insn    = rec_insn;
        e.use_rd  = rec_use_rd;
        e.rd_val  = rec_rs1;
        bad_align = (f3[1:0] == SIZE_HALF && off[0]) || (f3[1:0] == SIZE_WORD && off != 2'b00);
        if (rec_trap) begin
            e.trap  = 1'b1;
            e.cause = rec_cause;
        end else if ((op == OP_LOAD || op == OP_STORE) && bad_align) begin
            e.trap  = 1'b1;
            e.cause = op == OP_STORE ? CAUSE_STORE_MISALIGN : CAUSE_LOAD_MISALIGN;
        end else if (op == OP_LOAD) begin
            word = ram_model[idx];
            case (f3)
                3'b000:  e.rd_val = word_t'($signed(word[8*off +: 8]));
                3'b100:  e.rd_val = word_t'(word[8*off +: 8]);
                3'b001:  e.rd_val = word_t'($signed(word[8*off +: 16]));
                3'b101:  e.rd_val = word_t'(word[8*off +: 16]);
                default: e.rd_val = word;
            endcase
        end else if (op == OP_STORE) begin
            // A store that reached the bus commits even when cleared.
            case (f3[1:0])
                SIZE_BYTE: ram_model[idx][8*off +: 8] = rec_rs2[7:0];
                SIZE_HALF: ram_model[idx][8*off +: 16] = rec_rs2[15:0];
                default:   ram_model[idx] = rec_rs2;
            endcase
        end else if (op == OP_SYSTEM) begin
            exists = 1'b1;
            old    = '0;
            case (rec_insn[31:20])
                CSR_MSCRATCH:  old = mscratch_model;
                CSR_MTVEC:     old = mtvec_model;
                CSR_MVENDORID: old = '0;
                default:       exists = 1'b0;
            endcase
            src       = f3[2] ? word_t'(rec_insn[19:15]) : rec_rs1;
            write_csr = f3[1:0] == CSR_OP_RW || rec_insn[19:15] != 5'd0;
            e.rd_val  = old;
            if (!exists || (write_csr && rec_insn[31:20] == CSR_MVENDORID)) begin
                e.trap  = 1'b1;
                e.cause = CAUSE_ILLEGAL_INSN;
            end else if (write_csr && !cleared) begin
                case (f3[1:0])
                    CSR_OP_RW: word = src;
                    CSR_OP_RS: word = old | src;
                    default:   word = old & ~src;
                endcase
                if (rec_insn[31:20] == CSR_MSCRATCH) begin
                    mscratch_model = word;
                end else if (rec_insn[31:20] == CSR_MTVEC) begin
                    mtvec_model = word;
                end
            end
        end else if (op == OP_MISC_MEM) begin
            e.aq = rec_insn[27:24] != 4'd0;
            e.rl = rec_insn[23:20] != 4'd0;
        end
        if (!cleared) begin
            exp_q.push_back(e);
        end
    endtask

    // Returns at the negedge before the accepting edge.
    task automatic wait_for_accept();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!in_ready) begin
            if (cycles == WAIT_LIMIT) begin
                $display("Timed out at %0t waiting for the stage to accept an item", $time);
                end_with_failure();
            end else begin
                cycles++;
                @(negedge clk);
            end
        end
    endtask

    task automatic wait_for_drain();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0) begin
            if (cycles == WAIT_LIMIT) begin
                $display("Timed out at %0t with %0d results never retired", $time, exp_q.size());
                end_with_failure();
            end else begin
                cycles++;
                @(negedge clk);
            end
        end
    endtask

    // Output checker, sampled mid-cycle.
    always @(negedge clk) begin
        if (!rst) begin
            if (out_valid || out_trap) begin
                if (exp_q.size() == 0) begin
                    $display("An output retired at %0t with no accepted item pending", $time);
                    end_with_failure();
                end else begin
                    head = exp_q.pop_front();
                    check_equal("out_pc", word_t'(out_pc), word_t'(head.pc));
                    check_equal("out_insn", out_insn, head.insn);
                    check_equal("out_use_rd", word_t'(out_use_rd), word_t'(head.use_rd));
                    check_equal("out_trap", word_t'(out_trap), word_t'(head.trap));
                    check_equal("out_valid", word_t'(out_valid), word_t'(!head.trap));
                    if (head.trap) begin
                        check_equal("out_cause", word_t'(out_cause), word_t'(head.cause));
                    end else begin
                        check_equal("out_rd_val", out_rd_val, head.rd_val);
                    end
                    check_equal("fence_aq", word_t'(fence_aq), word_t'(head.aq));
                    check_equal("fence_rl", word_t'(fence_rl), word_t'(head.rl));
                end
            end else begin
                check_equal("fence_aq", word_t'(fence_aq), 32'd0);
                check_equal("fence_rl", word_t'(fence_rl), 32'd0);
            end
        end
    end

    initial begin
        void'($urandom(98542));
        rst        = 1'b1;
        clear      = 1'b0;
        in_valid   = 1'b0;
        in_pc      = '0;
        in_insn    = '0;
        in_use_rd  = 1'b0;
        in_rs1_val = '0;
        in_rs2_val = '0;
        in_trap    = 1'b0;
        in_cause   = '0;
        for (int i = 0; i < RAM_WORDS; i++) begin
            ram_model[i] = '0;
        end
        mscratch_model = '0;
        mtvec_model    = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_equal("in_ready", word_t'(in_ready), 32'd1);
        check_equal("out_valid", word_t'(out_valid), 32'd0);
        check_equal("out_trap", word_t'(out_trap), 32'd0);
        for (int n = 0; n < NUM_ITEMS; n++) begin
            random_record();
            @(posedge clk);
            clear      <= 1'b0;
            in_valid   <= 1'b1;
            in_pc      <= rec_pc;
            in_insn    <= rec_insn;
            in_use_rd  <= rec_use_rd;
            in_rs1_val <= rec_rs1;
            in_rs2_val <= rec_rs2;
            in_trap    <= rec_trap;
            in_cause   <= rec_cause;
            wait_for_accept();
            gap = int'($urandom_range(99, 0));
            predict_item(gap < 3);
            if (gap < 3) begin
                // Kill the item just accepted.
                @(posedge clk);
                in_valid <= 1'b0;
                clear    <= 1'b1;
            end else if (gap < 13) begin
                @(posedge clk);
                in_valid <= 1'b0;
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
        clear    <= 1'b0;
        wait_for_drain();
        // A few idle cycles so a stray output would still be caught.
        repeat (4) @(negedge clk);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: files.f
verilog/mem_stage_pkg.sv
verilog/mem_stage_if.sv
verilog/mem_access_unit.sv
verilog/data_ram.sv
verilog/csr_file.sv
verilog/mem_stage.sv
verilog/mem_subsystem_top.sv
dv/mem_subsystem_tb.sv

// File: verilog/csr_file.sv
// Holds mscratch and mtvec (all 32 bits writable) and a zero mvendorid; other addresses are absent.
module csr_file import mem_stage_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    csr_bus_if.csr csr
);

    word_t mscratch;
    word_t mtvec;

    // Address decode, purely combinational.
    always_comb begin
        csr.rdata  = '0;
        csr.exists = 1'b0;
        csr.rdonly = 1'b0;
        case (csr.addr)
            CSR_MSCRATCH: begin
                csr.rdata  = mscratch;
                csr.exists = 1'b1;
            end
            CSR_MTVEC: begin
                csr.rdata  = mtvec;
                csr.exists = 1'b1;
            end
            CSR_MVENDORID: begin
                // Non-commercial implementation.
                csr.exists = 1'b1;
                csr.rdonly = 1'b1;
            end
            default: begin
                csr.exists = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mscratch <= '0;
            mtvec    <= '0;
        end else if (csr.we) begin
            case (csr.addr)
                CSR_MSCRATCH: mscratch <= csr.wdata;
                CSR_MTVEC:    mtvec    <= csr.wdata;
                default:      ;
            endcase
        end
    end

    // The stage must have turned bad writes into traps.
    legal_write: assert property (
        @(posedge clk) disable iff (rst) csr.we |-> csr.exists && !csr.rdonly
    ) else $error("write to absent or read-only CSR");

endmodule

// File: verilog/data_ram.sv
// 256-word RAM with 0 to 3 pseudo-random wait states; contents start at zero and are not reset.
module data_ram import mem_stage_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    data_bus_if.mem bus
);

    typedef enum logic {
        RAM_IDLE,
        RAM_WAIT
    } ram_state_t;

    ram_state_t               state;
    logic [3:0]               lfsr;
    logic [1:0]               wait_cnt;
    logic                     req;
    logic [RAM_ADDR_BITS-1:0] index;
    word_t                    mem [RAM_WORDS];

    initial begin
        for (int i = 0; i < RAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    assign req       = bus.re || bus.we != 4'b0000;
    // Upper address bits are ignored, so accesses wrap.
    assign index     = bus.addr[RAM_ADDR_BITS-1:0];
    assign bus.rdata = mem[index];

    // Zero wait states answer in the first request cycle.
    always_comb begin
        case (state)
            RAM_IDLE: bus.ready = req && lfsr[1:0] == 2'd0;
            RAM_WAIT: bus.ready = req && wait_cnt == 2'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= RAM_IDLE;
            wait_cnt <= 2'd0;
            lfsr     <= 4'b0001;
        end else begin
            // x^4 + x^3 + 1.
            lfsr <= {lfsr[2:0], lfsr[3] ^ lfsr[2]};
            case (state)
                RAM_IDLE: begin
                    if (req && lfsr[1:0] != 2'd0) begin
                        state    <= RAM_WAIT;
                        wait_cnt <= lfsr[1:0] - 2'd1;
                    end
                end
                RAM_WAIT: begin
                    if (wait_cnt == 2'd0) begin
                        state <= RAM_IDLE;
                    end else begin
                        wait_cnt <= wait_cnt - 2'd1;
                    end
                end
            endcase
        end
    end

    // Byte-enabled write on the completing cycle.
    always @(posedge clk) begin
        if (bus.ready) begin
            for (int b = 0; b < 4; b++) begin
                if (bus.we[b]) begin
                    mem[index][8*b +: 8] <= bus.wdata[8*b +: 8];
                end
            end
        end
    end

    no_read_write: assert property (
        @(posedge clk) disable iff (rst) !(bus.re && bus.we != 4'b0000)
    ) else $error("read and write requested together");

endmodule

// File: verilog/mem_access_unit.sv
// Byte-lane formatter; caller must hold the request until done, size 3 is reported as misaligned.
module mem_access_unit import mem_stage_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         req_read,
    input  logic         req_write,
    // Sign-extend load data.
    input  logic         req_signed,
    input  access_size_t req_size,
    // Byte address.
    input  word_t        req_addr,
    input  word_t        req_wdata,
    output logic         misaligned,
    output logic         done,
    output word_t        load_data,
    data_bus_if.cpu      bus
);

    logic     align_err;
    byte_en_t lane_mask;
    word_t    lane_data;
    word_t    shifted;

    // Alignment check and lane mask.
    always_comb begin
        case (req_size)
            SIZE_BYTE: begin
                align_err = 1'b0;
                lane_mask = 4'b0001 << req_addr[1:0];
                lane_data = {4{req_wdata[7:0]}};
            end
            SIZE_HALF: begin
                align_err = req_addr[0];
                lane_mask = req_addr[1] ? 4'b1100 : 4'b0011;
                lane_data = {2{req_wdata[15:0]}};
            end
            SIZE_WORD: begin
                align_err = req_addr[1:0] != 2'b00;
                lane_mask = 4'b1111;
                lane_data = req_wdata;
            end
            default: begin
                align_err = 1'b1;
                lane_mask = 4'b0000;
                lane_data = req_wdata;
            end
        endcase
    end

    assign misaligned = (req_read || req_write) && align_err;

    // Misaligned requests never reach the bus.
    assign bus.addr  = {2'b00, req_addr[31:2]};
    assign bus.re    = req_read && !align_err;
    assign bus.we    = (req_write && !align_err) ? lane_mask : 4'b0000;
    assign bus.wdata = lane_data;

    assign done = bus.ready;

    // Move the addressed lane down to bit 0.
    assign shifted = bus.rdata >> {req_addr[1:0], 3'b000};

    always_comb begin
        case (req_size)
            SIZE_BYTE: load_data = {{24{req_signed && shifted[7]}}, shifted[7:0]};
            SIZE_HALF: load_data = {{16{req_signed && shifted[15]}}, shifted[15:0]};
            default:   load_data = bus.rdata;
        endcase
    end

    // The RAM may sample the request in any wait cycle, so it must not move.
    request_stable: assert property (
        @(posedge clk) disable iff (rst)
        (bus.re || bus.we != 4'b0000) && !bus.ready
        |=> $stable(bus.addr) && $stable(bus.re) && $stable(bus.we) && $stable(bus.wdata)
    ) else $error("data bus request changed before ready");

endmodule

// File: verilog/mem_stage.sv
// Writeback always accepts, and a cleared item with an issued access still completes it.
module mem_stage import mem_stage_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    clear,
    input  logic    in_valid,
    output logic    in_ready,
    input  pc_t     in_pc,
    input  insn_t   in_insn,
    input  logic    in_use_rd,
    // Address, ALU result or CSR source.
    input  word_t   in_rs1_val,
    // Store data.
    input  word_t   in_rs2_val,
    input  logic    in_trap,
    input  cause_t  in_cause,
    output logic    out_valid,
    output pc_t     out_pc,
    output insn_t   out_insn,
    output logic    out_use_rd,
    output word_t   out_rd_val,
    output logic    out_trap,
    output cause_t  out_cause,
    output logic    fence_aq,
    output logic    fence_rl,
    data_bus_if.cpu dbus,
    csr_bus_if.cpu  csr
);

    // Stage register.
    logic   r_valid;
    logic   r_kill;
    pc_t    r_pc;
    insn_t  r_insn;
    logic   r_use_rd;
    word_t  r_rs1_val;
    word_t  r_rs2_val;
    logic   r_trap;
    cause_t r_cause;

    logic       [4:0] opcode;
    logic       [2:0] funct3;
    logic             is_load;
    logic             is_store;
    logic             is_fence;
    logic             is_csr;
    logic             mem_op;
    logic             misaligned;
    logic             mem_done;
    logic             mem_wait;
    word_t            load_data;
    logic             retire;
    logic             emit;
    word_t            csr_mask;
    logic             csr_write_req;
    logic             csr_err;
    logic             trap_sel;

    assign opcode   = r_insn[6:2];
    assign funct3   = r_insn[14:12];
    assign is_load  = opcode == OP_LOAD;
    assign is_store = opcode == OP_STORE;
    assign is_fence = opcode == OP_MISC_MEM && funct3 == 3'b000;
    assign is_csr   = opcode == OP_SYSTEM && funct3[1:0] != 2'b00;

    // Request comes straight from the register, so it holds until ready.
    assign mem_op = r_valid && !r_trap && (is_load || is_store);

    mem_access_unit mem_access_unit_inst (
        .clk        (clk),
        .rst        (rst),
        .req_read   (mem_op && is_load),
        .req_write  (mem_op && is_store),
        .req_signed (!funct3[2]),
        .req_size   (funct3[1:0]),
        .req_addr   (r_rs1_val),
        .req_wdata  (r_rs2_val),
        .misaligned (misaligned),
        .done       (mem_done),
        .load_data  (load_data),
        .bus        (dbus)
    );

    assign mem_wait = mem_op && !misaligned && !mem_done;
    assign retire   = r_valid && !mem_wait;
    assign emit     = retire && !r_kill && !clear;
    assign in_ready = !clear && (!r_valid || retire);

    always_ff @(posedge clk) begin
        if (rst) begin
            r_valid <= 1'b0;
            r_kill  <= 1'b0;
        end else if (clear) begin
            // An access in flight runs to completion without output.
            if (mem_wait) begin
                r_kill <= 1'b1;
            end else begin
                r_valid <= 1'b0;
                r_kill  <= 1'b0;
            end
        end else if (in_ready) begin
            r_valid <= in_valid;
            r_kill  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            r_pc      <= in_pc;
            r_insn    <= in_insn;
            r_use_rd  <= in_use_rd;
            r_rs1_val <= in_rs1_val;
            r_rs2_val <= in_rs2_val;
            r_trap    <= in_trap;
            r_cause   <= in_cause;
        end
    end

    // CSR source is the rs1 value or the 5-bit immediate.
    assign csr.addr = r_insn[31:20];
    assign csr_mask = funct3[2] ? word_t'(r_insn[19:15]) : r_rs1_val;

    always_comb begin
        case (funct3[1:0])
            CSR_OP_RW: csr.wdata = csr_mask;
            CSR_OP_RS: csr.wdata = csr.rdata | csr_mask;
            CSR_OP_RC: csr.wdata = csr.rdata & ~csr_mask;
            default:   csr.wdata = csr.rdata;
        endcase
    end

    assign csr_write_req = is_csr && (funct3[1:0] == CSR_OP_RW || r_insn[19:15] != 5'd0);
    assign csr_err       = is_csr && (!csr.exists || (csr_write_req && csr.rdonly));

    // Traps from earlier stages take priority.
    assign trap_sel = r_trap || misaligned || csr_err;

    always_comb begin
        if (r_trap) begin
            out_cause = r_cause;
        end else if (misaligned) begin
            out_cause = is_store ? CAUSE_STORE_MISALIGN : CAUSE_LOAD_MISALIGN;
        end else begin
            out_cause = CAUSE_ILLEGAL_INSN;
        end
    end

    assign csr.we = emit && !trap_sel && csr_write_req;

    assign out_valid  = emit && !trap_sel;
    assign out_trap   = emit && trap_sel;
    assign out_pc     = r_pc;
    assign out_insn   = r_insn;
    assign out_use_rd = r_use_rd;

    always_comb begin
        if (is_csr) begin
            out_rd_val = csr.rdata;
        end else if (is_load) begin
            out_rd_val = load_data;
        end else begin
            out_rd_val = r_rs1_val;
        end
    end

    // One fence pulse per retiring FENCE.
    assign fence_aq = out_valid && is_fence && r_insn[27:24] != 4'd0;
    assign fence_rl = out_valid && is_fence && r_insn[23:20] != 4'd0;

    // A retired item is not presented again unless a new one was accepted.
    one_output_per_item: assert property (
        @(posedge clk) disable iff (rst)
        (out_valid || out_trap) && !(in_valid && in_ready) |=> !out_valid && !out_trap
    ) else $error("held item presented twice");

endmodule

// File: verilog/mem_stage_if.sv
// Data and CSR buses; a data request stays stable until ready, CSR responses are combinational.

// Word-wide data bus with byte write enables.
interface data_bus_if import mem_stage_pkg::*; ();

    // Word index, i.e. the byte address shifted right by two.
    word_t    addr;
    logic     re;
    byte_en_t we;
    word_t    wdata;
    word_t    rdata;
    // Access complete; write commits and read data is valid.
    logic     ready;

    modport cpu (
        output addr, re, we, wdata,
        input  rdata, ready
    );

    modport mem (
        input  addr, re, we, wdata,
        output rdata, ready
    );

endinterface

// CSR access bus.
interface csr_bus_if import mem_stage_pkg::*; ();

    csr_addr_t addr;
    logic      we;
    word_t     wdata;
    word_t     rdata;
    logic      exists;
    logic      rdonly;

    modport cpu (
        output addr, we, wdata,
        input  rdata, exists, rdonly
    );

    modport csr (
        input  addr, we, wdata,
        output rdata, exists, rdonly
    );

endinterface

// File: verilog/mem_stage_pkg.sv
// Shared types and constants; only the three CSRs below exist and RAM addresses wrap at 256 words.
package mem_stage_pkg;

    // Data words and byte addresses.
    typedef logic [31:0] word_t;
    // Instruction address, bit 0 is always zero and not stored.
    typedef logic [31:1] pc_t;
    // Raw instruction word.
    typedef logic [31:0] insn_t;
    // Trap cause code.
    typedef logic [3:0]  cause_t;
    // CSR number as found in insn[31:20].
    typedef logic [11:0] csr_addr_t;
    // One write enable per byte lane.
    typedef logic [3:0]  byte_en_t;
    // Access width, taken from funct3[1:0].
    typedef logic [1:0]  access_size_t;

    localparam access_size_t SIZE_BYTE = 2'd0;
    localparam access_size_t SIZE_HALF = 2'd1;
    localparam access_size_t SIZE_WORD = 2'd2;

    // Major opcodes, insn[6:2].
    localparam logic [4:0] OP_LOAD     = 5'b00000;
    localparam logic [4:0] OP_STORE    = 5'b01000;
    localparam logic [4:0] OP_MISC_MEM = 5'b00011;
    localparam logic [4:0] OP_SYSTEM   = 5'b11100;

    // CSR operation, funct3[1:0]; funct3[2] selects the immediate form.
    localparam logic [1:0] CSR_OP_RW = 2'b01;
    localparam logic [1:0] CSR_OP_RS = 2'b10;
    localparam logic [1:0] CSR_OP_RC = 2'b11;

    // Trap causes.
    localparam cause_t CAUSE_ILLEGAL_INSN   = 4'd2;
    localparam cause_t CAUSE_LOAD_MISALIGN  = 4'd4;
    localparam cause_t CAUSE_STORE_MISALIGN = 4'd6;

    // Implemented CSRs.
    localparam csr_addr_t CSR_MSCRATCH  = 12'h340;
    localparam csr_addr_t CSR_MTVEC     = 12'h305;
    localparam csr_addr_t CSR_MVENDORID = 12'hF11;

    // Data RAM geometry.
    localparam int RAM_ADDR_BITS = 8;
    localparam int RAM_WORDS     = 1 << RAM_ADDR_BITS;

endpackage

// File: verilog/mem_subsystem_top.sv
// Memory stage with its data RAM and CSR file; the output side has no back-pressure.
module mem_subsystem_top import mem_stage_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   clear,
    input  logic   in_valid,
    output logic   in_ready,
    input  pc_t    in_pc,
    input  insn_t  in_insn,
    input  logic   in_use_rd,
    input  word_t  in_rs1_val,
    input  word_t  in_rs2_val,
    input  logic   in_trap,
    input  cause_t in_cause,
    output logic   out_valid,
    output pc_t    out_pc,
    output insn_t  out_insn,
    output logic   out_use_rd,
    output word_t  out_rd_val,
    output logic   out_trap,
    output cause_t out_cause,
    output logic   fence_aq,
    output logic   fence_rl
);

    data_bus_if dbus ();
    csr_bus_if  csr_bus ();

    mem_stage mem_stage_inst (
        .clk        (clk),
        .rst        (rst),
        .clear      (clear),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_pc      (in_pc),
        .in_insn    (in_insn),
        .in_use_rd  (in_use_rd),
        .in_rs1_val (in_rs1_val),
        .in_rs2_val (in_rs2_val),
        .in_trap    (in_trap),
        .in_cause   (in_cause),
        .out_valid  (out_valid),
        .out_pc     (out_pc),
        .out_insn   (out_insn),
        .out_use_rd (out_use_rd),
        .out_rd_val (out_rd_val),
        .out_trap   (out_trap),
        .out_cause  (out_cause),
        .fence_aq   (fence_aq),
        .fence_rl   (fence_rl),
        .dbus       (dbus.cpu),
        .csr        (csr_bus.cpu)
    );

    data_ram data_ram_inst (
        .clk (clk),
        .rst (rst),
        .bus (dbus.mem)
    );

    csr_file csr_file_inst (
        .clk (clk),
        .rst (rst),
        .csr (csr_bus.csr)
    );

endmodule
